// File: verilog/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	localparam int DataWidth = 32; // Data, registers and addresses
	localparam int RegAddrWidth = 5;
	localparam int ImmWidth = 16;
	localparam int JumpWidth = 26;

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OpSpecial = 6'd0,
		OpJ = 6'd2,
		OpBeq = 6'd4,
		OpBne = 6'd5,
		OpAddiu = 6'd9,
		OpAndi = 6'd12,
		OpOri = 6'd13,
		OpLui = 6'd15,
		OpLw = 6'd35,
		OpSw = 6'd43
	} opcodeE;

	// Function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FnSll = 6'd0,
		FnAddu = 6'd33,
		FnSubu = 6'd35,
		FnAnd = 6'd36,
		FnOr = 6'd37,
		FnXor = 6'd38,
		FnNor = 6'd39,
		FnSlt = 6'd42
	} functE;

endpackage

`default_nettype wire

// File: verilog/mipsCorePkg.sv
`default_nettype none

package mipsCorePkg;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluNor,
		AluSlt, // Signed compare
		AluSll,
		AluLui
	} aluOpE;

	typedef enum logic [1:0] {
		SrcReg,
		SrcSignImm,
		SrcZeroImm
	} aluSrcE;

	typedef enum logic [1:0] {
		BrNone,
		BrEqual,
		BrNotEqual
	} branchE;

	localparam int ImemDepth = 64; // Words
	localparam int DmemDepth = 64;
	localparam logic [31:0] ResetPc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: verilog/programCounter.sv
`default_nettype none

module programCounter (
	input  logic                             Clk,
	input  logic                             rstN,
	input  mipsCorePkg::branchE              branch,
	input  logic                             jump,
	input  logic                             zero,
	input  logic [mipsIsaPkg::ImmWidth-1:0]  imm,
	input  logic [mipsIsaPkg::JumpWidth-1:0] jumpTarget,
	output logic [mipsIsaPkg::DataWidth-1:0] pc
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	logic [DataWidth-1:0] pcPlus4;
	logic [DataWidth-1:0] branchOffset;
	logic [DataWidth-1:0] nextPc;
	logic taken;

	assign pcPlus4 = pc + 32'd4;
	assign branchOffset = {{(DataWidth - ImmWidth - 2){imm[ImmWidth-1]}}, imm, 2'b00};
	assign taken = (branch == BrEqual && zero) || (branch == BrNotEqual && !zero);

	always_comb begin
		if (jump)
			nextPc = {pcPlus4[DataWidth-1:DataWidth-4], jumpTarget, 2'b00}; // Same 256MB region
		else if (taken)
			nextPc = pcPlus4 + branchOffset;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			pc <= ResetPc;
		else
			pc <= nextPc;
	end

	pcAligned: assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: verilog/controlDecoder.sv
`default_nettype none

module controlDecoder (
	input  logic [mipsIsaPkg::DataWidth-1:0] instr,
	output mipsCorePkg::aluOpE               aluOp,
	output mipsCorePkg::aluSrcE              aluSrc,
	output logic                             regDst,
	output logic                             memToReg,
	output logic                             regWe,
	output logic                             memWe,
	output mipsCorePkg::branchE              branch,
	output logic                             jump
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	opcodeE opcode;
	functE funct;

	assign opcode = opcodeE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);

	always_comb begin
		aluOp = AluAdd;
		aluSrc = SrcReg;
		regDst = 1'b0;
		memToReg = 1'b0;
		regWe = 1'b0;
		memWe = 1'b0;
		branch = BrNone;
		jump = 1'b0;
		if (instr != '0) begin // All-zero word is a no-op
			case (opcode)
				OpSpecial: begin
					regDst = 1'b1;
					regWe = 1'b1;
					case (funct)
						FnSll: aluOp = AluSll;
						FnAddu: aluOp = AluAdd;
						FnSubu: aluOp = AluSub;
						FnAnd: aluOp = AluAnd;
						FnOr: aluOp = AluOr;
						FnXor: aluOp = AluXor;
						FnNor: aluOp = AluNor;
						FnSlt: aluOp = AluSlt;
						default: begin
							regDst = 1'b0;
							regWe = 1'b0;
						end
					endcase
				end
				OpAddiu: begin
					aluSrc = SrcSignImm;
					regWe = 1'b1;
				end
				OpAndi: begin
					aluOp = AluAnd;
					aluSrc = SrcZeroImm;
					regWe = 1'b1;
				end
				OpOri: begin
					aluOp = AluOr;
					aluSrc = SrcZeroImm;
					regWe = 1'b1;
				end
				OpLui: begin
					aluOp = AluLui;
					regWe = 1'b1;
				end
				OpLw: begin
					aluSrc = SrcSignImm; // base + offset
					memToReg = 1'b1;
					regWe = 1'b1;
				end
				OpSw: begin
					aluSrc = SrcSignImm;
					memWe = 1'b1;
				end
				OpBeq: begin
					aluOp = AluSub; // zero flag compares rs and rt
					branch = BrEqual;
				end
				OpBne: begin
					aluOp = AluSub;
					branch = BrNotEqual;
				end
				OpJ: jump = 1'b1;
				default: ;
			endcase
		end
		writeExclusive: assert (!(regWe && memWe))
			else $error("regWe and memWe both set for %h", instr);
	end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`default_nettype none

module registerFile (
	input  logic                                Clk,
	input  logic                                rstN,
	input  logic [mipsIsaPkg::RegAddrWidth-1:0] rs,
	input  logic [mipsIsaPkg::RegAddrWidth-1:0] rt,
	input  logic [mipsIsaPkg::RegAddrWidth-1:0] rd,
	input  logic                                regDst,
	input  logic                                memToReg,
	input  logic                                regWe,
	input  logic [mipsIsaPkg::DataWidth-1:0]    aluResult,
	input  logic [mipsIsaPkg::DataWidth-1:0]    loadData,
	output logic [mipsIsaPkg::DataWidth-1:0]    readData1,
	output logic [mipsIsaPkg::DataWidth-1:0]    readData2,
	output logic [mipsIsaPkg::RegAddrWidth-1:0] wAddr,
	output logic [mipsIsaPkg::DataWidth-1:0]    wData
);
	import mipsIsaPkg::*;

	logic [DataWidth-1:0] regs [2**RegAddrWidth];

	assign wAddr = regDst ? rd : rt; // rd for R-type
	assign wData = memToReg ? loadData : aluResult;

	assign readData1 = regs[rs];
	assign readData2 = regs[rt];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**RegAddrWidth; i++)
				regs[i] <= '0;
		end else if (regWe && wAddr != '0) begin // $0 stays zero
			regs[wAddr] <= wData;
		end
	end

	zeroReg: assert property (@(posedge Clk) disable iff (!rstN) rs == '0 |-> readData1 == '0)
		else $error("register 0 read as %h", readData1);

endmodule

`default_nettype wire

// File: verilog/aluStage.sv
`default_nettype none

module aluStage (
	input  mipsCorePkg::aluOpE               aluOp,
	input  mipsCorePkg::aluSrcE              aluSrc,
	input  logic [mipsIsaPkg::DataWidth-1:0] a,
	input  logic [mipsIsaPkg::DataWidth-1:0] regB,
	input  logic [mipsIsaPkg::ImmWidth-1:0]  imm,
	input  logic [4:0]                       shamt,
	output logic [mipsIsaPkg::DataWidth-1:0] result,
	output logic                             zero
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	logic [DataWidth-1:0] signImm;
	logic [DataWidth-1:0] zeroImm;
	logic [DataWidth-1:0] b;

	assign signImm = {{(DataWidth - ImmWidth){imm[ImmWidth-1]}}, imm};
	assign zeroImm = {{(DataWidth - ImmWidth){1'b0}}, imm};

	always_comb begin
		case (aluSrc)
			SrcSignImm: b = signImm;
			SrcZeroImm: b = zeroImm;
			default: b = regB;
		endcase
	end

	always_comb begin
		case (aluOp)
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluAnd: result = a & b;
			AluOr: result = a | b;
			AluXor: result = a ^ b;
			AluNor: result = ~(a | b);
			AluSlt: result = {{(DataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
			AluSll: result = regB << shamt; // rt shifted, rs unused
			AluLui: result = {imm, {(DataWidth - ImmWidth){1'b0}}};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/dataMemory.sv
`default_nettype none

module dataMemory (
	input  logic                             Clk,
	input  logic                             rstN,
	input  logic                             memWe,
	input  logic [mipsIsaPkg::DataWidth-1:0] addr,
	input  logic [mipsIsaPkg::DataWidth-1:0] wData,
	output logic [mipsIsaPkg::DataWidth-1:0] loadData
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	localparam int IndexWidth = $clog2(DmemDepth);

	logic [DataWidth-1:0] mem [DmemDepth];
	logic [IndexWidth-1:0] index;

	// Byte address, low two bits dropped, upper bits wrap
	assign index = addr[IndexWidth+1:2];

	assign loadData = mem[index];

	always_ff @(posedge Clk) begin
		if (rstN && memWe) // Decode of garbage during reset must not write
			mem[index] <= wData;
	end

endmodule

`default_nettype wire

// File: verilog/instructionMemory.sv
`default_nettype none

module instructionMemory (
	input  logic                             Clk,
	input  logic [mipsIsaPkg::DataWidth-1:0] pc,
	input  logic                             imemLoad,
	input  logic [mipsIsaPkg::DataWidth-1:0] imemLoadAddr, // Byte address, like pc
	input  logic [mipsIsaPkg::DataWidth-1:0] imemLoadData,
	output logic [mipsIsaPkg::DataWidth-1:0] instr
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	localparam int IndexWidth = $clog2(ImemDepth);

	logic [DataWidth-1:0] mem [ImemDepth];

	assign instr = mem[pc[IndexWidth+1:2]];

	always_ff @(posedge Clk) begin
		if (imemLoad)
			mem[imemLoadAddr[IndexWidth+1:2]] <= imemLoadData;
	end

endmodule

`default_nettype wire

// File: verilog/mipsCore.sv
`default_nettype none

module mipsCore (
	input  logic                                Clk,
	input  logic                                rstN,
	input  logic                                imemLoad,
	input  logic [mipsIsaPkg::DataWidth-1:0]    imemLoadAddr,
	input  logic [mipsIsaPkg::DataWidth-1:0]    imemLoadData,
	output logic [mipsIsaPkg::DataWidth-1:0]    pc,
	output logic                                regWe,
	output logic [mipsIsaPkg::RegAddrWidth-1:0] regWaddr,
	output logic [mipsIsaPkg::DataWidth-1:0]    regWdata,
	output logic                                memWe,
	output logic [mipsIsaPkg::DataWidth-1:0]    memAddr,
	output logic [mipsIsaPkg::DataWidth-1:0]    memWdata
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	logic [DataWidth-1:0] instr;
	aluOpE aluOp;
	aluSrcE aluSrc;
	branchE branch;
	logic regDst;
	logic memToReg;
	logic jump;
	logic zero;
	logic [DataWidth-1:0] readData1;
	logic [DataWidth-1:0] readData2;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] loadData;

	assign memAddr = aluResult;
	assign memWdata = readData2; // SW stores rt

	instructionMemory imem (.Clk, .pc, .imemLoad, .imemLoadAddr, .imemLoadData, .instr);

	controlDecoder decoder (
		.instr, .aluOp, .aluSrc, .regDst, .memToReg, .regWe, .memWe, .branch, .jump
	);

	programCounter pcReg (
		.Clk, .rstN, .branch, .jump, .zero,
		.imm(instr[15:0]),
		.jumpTarget(instr[25:0]),
		.pc
	);

	registerFile regFile (
		.Clk, .rstN,
		.rs(instr[25:21]),
		.rt(instr[20:16]),
		.rd(instr[15:11]),
		.regDst, .memToReg, .regWe, .aluResult, .loadData,
		.readData1, .readData2,
		.wAddr(regWaddr),
		.wData(regWdata)
	);

	aluStage alu (
		.aluOp, .aluSrc,
		.a(readData1),
		.regB(readData2),
		.imm(instr[15:0]),
		.shamt(instr[10:6]),
		.result(aluResult),
		.zero
	);

	dataMemory dmem (.Clk, .rstN, .memWe, .addr(aluResult), .wData(readData2), .loadData);

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`default_nettype none

module clockGen (
	output logic Clk
);
	localparam int Period = 100;

	initial Clk = 1'b0;

	always #(Period / 2) Clk = ~Clk;

endmodule

`default_nettype wire

// File: verification/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	localparam int ClkPeriod = 100;
	localparam int ResetCycles = 10;
	localparam int IIdx = $clog2(ImemDepth);
	localparam int DIdx = $clog2(DmemDepth);

	logic Clk;
	logic rstN;
	logic imemLoad;
	logic [DataWidth-1:0] imemLoadAddr;
	logic [DataWidth-1:0] imemLoadData;
	logic [DataWidth-1:0] pc;
	logic regWe;
	logic [RegAddrWidth-1:0] regWaddr;
	logic [DataWidth-1:0] regWdata;
	logic memWe;
	logic [DataWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWdata;

	logic [DataWidth-1:0] progMem [ImemDepth];
	int progLen = 0;
	bit programReady = 1'b0;
	logic [DataWidth-1:0] haltPc;
	logic [31:0] lcgState = 32'h4e095c05;

	// ISA model state and decode of the instruction at modelPc
	logic [DataWidth-1:0] modelRegs [32];
	logic [DataWidth-1:0] modelDmem [DmemDepth];
	logic [DataWidth-1:0] modelPc;
	logic decRegWe;
	logic decMemWe;
	logic [RegAddrWidth-1:0] decWaddr;
	logic [DataWidth-1:0] decWdata;
	logic [DataWidth-1:0] decMemAddr;
	logic [DataWidth-1:0] decMemWdata;
	logic [DataWidth-1:0] decNextPc;

	logic [DataWidth-1:0] expPc; // Updated with NBAs like the DUT
	logic expRegWe;
	logic [RegAddrWidth-1:0] expRegWaddr;
	logic [DataWidth-1:0] expRegWdata;
	logic expMemWe;
	logic [DataWidth-1:0] expMemAddr;
	logic [DataWidth-1:0] expMemWdata;

	clockGen clkGen (.Clk);

	mipsCore uut (
		.Clk, .rstN, .imemLoad, .imemLoadAddr, .imemLoadData,
		.pc, .regWe, .regWaddr, .regWdata, .memWe, .memAddr, .memWdata
	);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [15:0] randHalf();
		logic [31:0] r;
		r = nextRand();
		return r[31:16]; // Upper bits are the better ones
	endfunction

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] shamt, input functE fn);
		return {OpSpecial, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeE op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input logic [25:0] target);
		return {OpJ, target};
	endfunction

	function automatic logic [DIdx-1:0] wordIndex(input logic [DataWidth-1:0] addr);
		return addr[DIdx+1:2];
	endfunction

	task automatic emit(input logic [31:0] word);
		progMem[progLen] = word;
		progLen++;
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		for (int i = 0; i < ImemDepth; i++)
			progMem[i] = '0;
		emit(rType(5'd2, 5'd3, 5'd1, 5'd0, FnAddu)); // Cleared registers give 0
		emit(iType(OpAddiu, 5'd0, 5'd2, randHalf() | 16'h8000));
		emit(iType(OpAndi, 5'd2, 5'd3, randHalf() | 16'h8000));
		emit(iType(OpOri, 5'd0, 5'd4, randHalf() | 16'h8000));
		emit(iType(OpLui, 5'd0, 5'd5, randHalf()));
		emit(iType(OpOri, 5'd5, 5'd5, randHalf() | 16'h0001)); // r5 never zero
		emit(iType(OpLui, 5'd0, 5'd6, randHalf()));
		emit(iType(OpOri, 5'd6, 5'd6, randHalf()));
		emit(rType(5'd5, 5'd6, 5'd7, 5'd0, FnAddu));
		emit(rType(5'd5, 5'd6, 5'd8, 5'd0, FnSubu));
		emit(rType(5'd5, 5'd6, 5'd9, 5'd0, FnAnd));
		emit(rType(5'd5, 5'd6, 5'd10, 5'd0, FnOr));
		emit(rType(5'd5, 5'd6, 5'd11, 5'd0, FnXor));
		emit(rType(5'd5, 5'd6, 5'd12, 5'd0, FnNor));
		emit(rType(5'd5, 5'd6, 5'd13, 5'd0, FnSlt));
		emit(rType(5'd6, 5'd5, 5'd14, 5'd0, FnSlt));
		r = nextRand();
		emit(rType(5'd0, 5'd5, 5'd15, r[31:27], FnSll));
		r = nextRand();
		emit(iType(OpAddiu, 5'd0, 5'd16, {9'd0, r[31:27], 2'b00})); // Word-aligned base
		emit(iType(OpSw, 5'd16, 5'd5, 16'd8));
		emit(iType(OpSw, 5'd16, 5'd7, 16'hfffc));
		emit(iType(OpLw, 5'd16, 5'd17, 16'd8));
		emit(iType(OpLw, 5'd16, 5'd18, 16'hfffc));
		emit(iType(OpBeq, 5'd5, 5'd5, 16'd1)); // Taken
		emit(iType(OpAddiu, 5'd0, 5'd19, 16'd1));
		emit(iType(OpBne, 5'd5, 5'd5, 16'd1)); // Not taken
		emit(iType(OpAddiu, 5'd0, 5'd20, 16'd7));
		emit(iType(OpBne, 5'd5, 5'd0, 16'd1));
		emit(iType(OpAddiu, 5'd0, 5'd19, 16'd2));
		emit(iType(OpBeq, 5'd5, 5'd0, 16'd1));
		emit(iType(OpAddiu, 5'd0, 5'd21, 16'd3));
		emit(iType(OpAddiu, 5'd21, 5'd21, 16'hffff)); // Loop body
		emit(iType(OpBne, 5'd21, 5'd0, 16'hfffe)); // Backward branch
		emit(jType(26'(progLen + 2)));
		emit(iType(OpAddiu, 5'd0, 5'd22, 16'd5)); // Jumped over
		emit(iType(OpAddiu, 5'd0, 5'd0, randHalf() | 16'h0001));
		emit(rType(5'd0, 5'd0, 5'd23, 5'd0, FnAddu));
		emit(rType(5'd0, 5'd5, 5'd24, 5'd0, FnOr));
		emit(rType(5'd5, 5'd6, 5'd0, 5'd0, FnXor));
		emit(rType(5'd0, 5'd6, 5'd25, 5'd0, FnSubu));
		haltPc = 32'(progLen * 4);
		emit(jType(26'(progLen))); // Jump to itself
	endtask

	task automatic setRegWrite(input logic [4:0] addr, input logic [DataWidth-1:0] value);
		decRegWe = 1'b1;
		decWaddr = addr;
		decWdata = value;
	endtask

	task automatic decodeModel();
		logic [31:0] instr;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [DataWidth-1:0] sImm;
		logic [DataWidth-1:0] zImm;
		logic [DataWidth-1:0] pcPlus4;
		logic [4:0] rt;
		logic [4:0] rd;
		instr = progMem[modelPc[IIdx+1:2]];
		rt = instr[20:16];
		rd = instr[15:11];
		a = modelRegs[instr[25:21]];
		b = modelRegs[rt];
		sImm = {{16{instr[15]}}, instr[15:0]};
		zImm = {16'h0000, instr[15:0]};
		pcPlus4 = modelPc + 32'd4;
		decRegWe = 1'b0;
		decMemWe = 1'b0;
		decWaddr = rt;
		decWdata = '0;
		decMemAddr = '0;
		decMemWdata = b;
		decNextPc = pcPlus4;
		if (instr != '0) begin
			case (opcodeE'(instr[31:26]))
				OpSpecial: begin
					case (functE'(instr[5:0]))
						FnSll: setRegWrite(rd, b << instr[10:6]);
						FnAddu: setRegWrite(rd, a + b);
						FnSubu: setRegWrite(rd, a - b);
						FnAnd: setRegWrite(rd, a & b);
						FnOr: setRegWrite(rd, a | b);
						FnXor: setRegWrite(rd, a ^ b);
						FnNor: setRegWrite(rd, ~(a | b));
						FnSlt: setRegWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				end
				OpAddiu: setRegWrite(rt, a + sImm);
				OpAndi: setRegWrite(rt, a & zImm);
				OpOri: setRegWrite(rt, a | zImm);
				OpLui: setRegWrite(rt, {instr[15:0], 16'h0000});
				OpLw: setRegWrite(rt, modelDmem[wordIndex(a + sImm)]);
				OpSw: begin
					decMemWe = 1'b1;
					decMemAddr = a + sImm;
				end
				OpBeq: if (a == b) decNextPc = pcPlus4 + {sImm[29:0], 2'b00};
				OpBne: if (a != b) decNextPc = pcPlus4 + {sImm[29:0], 2'b00};
				OpJ: decNextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
				default: ;
			endcase
		end
	endtask

	always @(posedge Clk) begin
		if (!rstN) begin
			modelPc = ResetPc;
			for (int i = 0; i < 32; i++)
				modelRegs[i] = '0;
		end else begin
			if (decRegWe && decWaddr != 5'd0) // $0 discards writes
				modelRegs[decWaddr] = decWdata;
			if (decMemWe)
				modelDmem[wordIndex(decMemAddr)] = decMemWdata;
			modelPc = decNextPc;
		end
		decodeModel();
		expPc <= modelPc;
		expRegWe <= decRegWe;
		expRegWaddr <= decWaddr;
		expRegWdata <= decWdata;
		expMemWe <= decMemWe;
		expMemAddr <= decMemAddr;
		expMemWdata <= decMemWdata;
	end

	task automatic abortRun();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("Fail %s: got %h, expected %h", name, got, want);
		abortRun();
	endtask

	pcCheck: assert property (@(posedge Clk) disable iff (!rstN) pc == expPc)
		else reportMismatch("pc", $sampled(pc), $sampled(expPc));
	regWeCheck: assert property (@(posedge Clk) disable iff (!rstN) regWe == expRegWe)
		else reportMismatch("regWe", 32'($sampled(regWe)), 32'($sampled(expRegWe)));
	regWaddrCheck: assert property (@(posedge Clk) disable iff (!rstN)
			expRegWe |-> regWaddr == expRegWaddr)
		else reportMismatch("regWaddr", 32'($sampled(regWaddr)), 32'($sampled(expRegWaddr)));
	regWdataCheck: assert property (@(posedge Clk) disable iff (!rstN)
			expRegWe |-> regWdata == expRegWdata)
		else reportMismatch("regWdata", $sampled(regWdata), $sampled(expRegWdata));
	memWeCheck: assert property (@(posedge Clk) disable iff (!rstN) memWe == expMemWe)
		else reportMismatch("memWe", 32'($sampled(memWe)), 32'($sampled(expMemWe)));
	memAddrCheck: assert property (@(posedge Clk) disable iff (!rstN)
			expMemWe |-> memAddr == expMemAddr)
		else reportMismatch("memAddr", $sampled(memAddr), $sampled(expMemAddr));
	memWdataCheck: assert property (@(posedge Clk) disable iff (!rstN)
			expMemWe |-> memWdata == expMemWdata)
		else reportMismatch("memWdata", $sampled(memWdata), $sampled(expMemWdata));

	// Load takes progLen + 1 cycles, then the reset tail, then one cycle per instruction
	initial begin
		wait (programReady);
		#((progLen + (progLen + 1) + ResetCycles + 20) * ClkPeriod);
		$display("Timeout: the program never reached its final jump");
		abortRun();
	end

	initial begin
		rstN <= 1'b0;
		imemLoad <= 1'b0;
		imemLoadAddr <= '0;
		imemLoadData <= '0;
		buildProgram();
		programReady = 1'b1;
		for (int i = 0; i < progLen; i++) begin
			@(posedge Clk);
			imemLoad <= 1'b1;
			imemLoadAddr <= 32'(i * 4);
			imemLoadData <= progMem[i];
		end
		@(posedge Clk);
		imemLoad <= 1'b0;
		repeat (ResetCycles) @(posedge Clk);
		rstN <= 1'b1;
		while (expPc != haltPc)
			@(posedge Clk);
		repeat (2) @(posedge Clk); // Self jump retires twice
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mipsLite.f
verilog/mipsIsaPkg.sv
verilog/mipsCorePkg.sv
verilog/programCounter.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/aluStage.sv
verilog/dataMemory.sv
verilog/instructionMemory.sv
verilog/mipsCore.sv
verification/clockGen.sv
verification/mipsCoreTb.sv

// File: Makefile
obj_dir/VmipsCoreTb: mipsLite.f $(shell cat mipsLite.f)
	verilator --binary --timing --assert --top-module mipsCoreTb -f mipsLite.f

run: obj_dir/VmipsCoreTb
	@out="$$(./obj_dir/VmipsCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
